// ==== src/mmio_pkg.sv ====
// Odd parity on address and data; addresses are [0:23] with bit 23 picking the 32-bit lane of a word
package mmio_pkg;

  // Host request as it arrives on the command link
  typedef struct packed {
    logic        cfg;
    logic        read;
    logic        doubleword;
    logic [0:23] address;
    logic        address_parity;
    logic [63:0] data;
    logic        data_parity;
  } mmio_req_t;

  typedef enum logic [2:0] {
    OP_CFG_READ,
    OP_REG_READ,
    OP_REG_WRITE,
    OP_CFG_WRITE,
    OP_BAD_PARITY
  } mmio_op_e;

  // Classified request, parity_err is {data, address}
  typedef struct packed {
    mmio_op_e    op;
    logic [0:23] address;
    logic        doubleword;
    logic [63:0] data;
    logic [1:0]  parity_err;
  } mmio_op_t;

  // Register space, even word addresses only
  typedef enum logic [23:0] {
    CU_CONFIGURE      = 24'h00_0010,
    AFU_CONFIGURE     = 24'h00_0012,
    CU_STATUS         = 24'h00_0014,
    ERROR_REG         = 24'h00_0016,
    ERROR_ACK         = 24'h00_0018,
    STAT_CLEAR        = 24'h00_001A,
    DONE_COUNT_REG    = 24'h00_0020,
    FLUSHED_COUNT_REG = 24'h00_0022,
    FAILED_COUNT_REG  = 24'h00_0024,
    PAGED_COUNT_REG   = 24'h00_0026,
    CYCLE_COUNT_REG   = 24'h00_0028
  } mmio_reg_addr_e;

  typedef struct packed {
    logic [63:0] data;
    logic        data_parity;
    logic        error;
    logic        was_write;
  } mmio_resp_t;

  typedef enum logic [1:0] {
    RESP_DONE,
    RESP_FLUSHED,
    RESP_FAILED,
    RESP_PAGED
  } cu_resp_code_e;

  typedef struct packed {
    logic          valid;
    cu_resp_code_e code;
  } cu_resp_t;

  typedef struct packed {
    logic [63:0] done;
    logic [63:0] flushed;
    logic [63:0] failed;
    logic [63:0] paged;
    logic [63:0] cycle;
  } resp_stats_t;

  ////////////////////
  // Descriptor space
  ////////////////////

  localparam int DESC_WORDS = 4;

  // Dedicated-process model, one config record at offset 0x100
  localparam logic [63:0] DESCRIPTOR_TABLE [DESC_WORDS] = '{
    64'h0000_0001_0001_8010,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0001,
    64'h0000_0000_0000_0100
  };

  // Parity bit that makes the total count of ones odd
  function automatic logic odd_parity_of(input logic [63:0] value);
    return ~(^value);
  endfunction

endpackage

// ==== src/mmio_req_check.sv ====
// Data parity is checked for writes only; a request with any parity error is never executed
`timescale 1ns/1ps

module mmio_req_check (
  input  logic                clock,
  input  logic                rstn,
  input  logic                advance,
  input  logic                req_valid,
  input  mmio_pkg::mmio_req_t req,
  output logic                op_valid,
  output mmio_pkg::mmio_op_t  op
);

  import mmio_pkg::*;

  logic     addr_err;
  logic     data_err;
  mmio_op_t next_op;

  ////////////////////
  // Parity check
  ////////////////////

  // Address is zero-extended, which leaves its parity unchanged
  assign addr_err = odd_parity_of({40'b0, req.address}) != req.address_parity;
  assign data_err = !req.read && (odd_parity_of(req.data) != req.data_parity);

  ////////////////////
  // Classification
  ////////////////////

  always_comb begin
    next_op.address    = req.address;
    next_op.doubleword = req.doubleword;
    next_op.data       = req.data;
    next_op.parity_err = {data_err, addr_err};
    if (addr_err || data_err) begin
      next_op.op = OP_BAD_PARITY;
    end else begin
      case ({req.cfg, req.read})
        2'b11:   next_op.op = OP_CFG_READ;
        2'b10:   next_op.op = OP_CFG_WRITE;
        2'b01:   next_op.op = OP_REG_READ;
        default: next_op.op = OP_REG_WRITE;
      endcase
    end
  end

  // Stage valid follows the pipeline advance
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      op_valid <= 1'b0;
    end else if (advance) begin
      op_valid <= req_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (advance && req_valid) begin
      op <= next_op;
    end
  end

  // A stalled operation must not change under the register stage
  assert property (@(posedge clock) disable iff (!rstn)
    op_valid && !advance |=> $stable(op) && op_valid);

endmodule

// ==== src/mmio_regs.sv ====
// Single-word data sits in the lane it addresses; descriptor writes are accepted and dropped
`timescale 1ns/1ps

module mmio_regs (
  input  logic                  clock,
  input  logic                  rstn,
  input  logic                  advance,
  input  logic                  op_valid,
  input  mmio_pkg::mmio_op_t    op,
  input  logic [63:0]           cu_status,
  input  mmio_pkg::resp_stats_t stats,
  output logic                  stat_clear,
  output logic [63:0]           cu_configure,
  output logic [63:0]           afu_configure,
  output logic [1:0]            mmio_errors,
  output logic                  rd_valid,
  output logic [63:0]           rd_data,
  output logic                  rd_error,
  output logic                  rd_write,
  output logic                  rd_addr_lo,
  output logic                  rd_double
);

  import mmio_pkg::*;

  logic        do_op;
  logic [23:0] word_addr;
  logic [1:0]  ack_bits;
  logic [63:0] read_value;

  // Replace the whole word or only the addressed 32-bit lane
  function automatic logic [63:0] merge_lane(input logic [63:0] old_value,
                                             input logic [63:0] new_value,
                                             input logic        full,
                                             input logic        lo);
    logic [63:0] result;
    result = old_value;
    if (full) begin
      result = new_value;
    end else if (lo) begin
      result[31:0] = new_value[31:0];
    end else begin
      result[63:32] = new_value[63:32];
    end
    return result;
  endfunction

  assign do_op     = advance && op_valid;
  assign word_addr = {op.address[0:22], 1'b0};
  assign ack_bits  = (op.doubleword || op.address[23]) ? op.data[1:0] : op.data[33:32];

  ////////////////////
  // Read selection
  ////////////////////

  always_comb begin
    read_value = '0;
    case (op.op)
      OP_CFG_READ: begin
        // Past the table reads as zero
        if (op.address[0:22] < DESC_WORDS) begin
          read_value = DESCRIPTOR_TABLE[op.address[21:22]];
        end
      end
      OP_REG_READ: begin
        case (word_addr)
          CU_CONFIGURE:      read_value = cu_configure;
          AFU_CONFIGURE:     read_value = afu_configure;
          CU_STATUS:         read_value = cu_status;
          ERROR_REG:         read_value = {62'b0, mmio_errors};
          DONE_COUNT_REG:    read_value = stats.done;
          FLUSHED_COUNT_REG: read_value = stats.flushed;
          FAILED_COUNT_REG:  read_value = stats.failed;
          PAGED_COUNT_REG:   read_value = stats.paged;
          CYCLE_COUNT_REG:   read_value = stats.cycle;
          default:           read_value = '0;
        endcase
      end
      default: read_value = '0;
    endcase
  end

  ////////////////////
  // Register writes
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cu_configure  <= '0;
      afu_configure <= '0;
      mmio_errors   <= '0;
      stat_clear    <= 1'b0;
      rd_valid      <= 1'b0;
    end else begin
      stat_clear <= 1'b0;
      if (advance) begin
        rd_valid <= op_valid;
      end
      if (do_op && op.op == OP_BAD_PARITY) begin
        mmio_errors <= mmio_errors | op.parity_err;
      end else if (do_op && op.op == OP_REG_WRITE) begin
        case (word_addr)
          CU_CONFIGURE:  cu_configure  <= merge_lane(cu_configure, op.data,
                                                     op.doubleword, op.address[23]);
          AFU_CONFIGURE: afu_configure <= merge_lane(afu_configure, op.data,
                                                     op.doubleword, op.address[23]);
          ERROR_ACK:     mmio_errors   <= mmio_errors & ~ack_bits;
          // Back-to-back clears merge into one pulse
          STAT_CLEAR:    stat_clear    <= !stat_clear;
          default: ;
        endcase
      end
    end
  end

  // Read payload for the output stage
  always_ff @(posedge clock) begin
    if (do_op) begin
      rd_data    <= read_value;
      rd_error   <= op.op == OP_BAD_PARITY;
      rd_write   <= op.op inside {OP_REG_WRITE, OP_CFG_WRITE};
      rd_addr_lo <= op.address[23];
      rd_double  <= op.doubleword;
    end
  end

  // Counters see a single clear edge per request
  assert property (@(posedge clock) disable iff (!rstn) stat_clear |=> !stat_clear);

endmodule

// ==== src/response_counters.sv ====
// Event counts saturate at COUNT_W bits; the cycle count wraps and is not cleared by stat_clear
`timescale 1ns/1ps

module response_counters #(
  parameter int COUNT_W = 32
) (
  input  logic                  clock,
  input  logic                  rstn,
  input  mmio_pkg::cu_resp_t    cu_resp,
  input  logic                  stat_clear,
  output mmio_pkg::resp_stats_t stats
);

  import mmio_pkg::*;

  logic [COUNT_W-1:0] event_count [4];
  logic [COUNT_W-1:0] cycle_count;

  ////////////////////
  // Event counters
  ////////////////////

  // Clear has priority over an event in the same cycle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 4; i++) begin
        event_count[i] <= '0;
      end
    end else if (stat_clear) begin
      for (int i = 0; i < 4; i++) begin
        event_count[i] <= '0;
      end
    end else if (cu_resp.valid && event_count[cu_resp.code] != '1) begin
      event_count[cu_resp.code] <= event_count[cu_resp.code] + 1'b1;
    end
  end

  // Free-running
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_count + 1'b1;
    end
  end

  // Zero-extend into the 64-bit register view
  assign stats.done    = 64'(event_count[RESP_DONE]);
  assign stats.flushed = 64'(event_count[RESP_FLUSHED]);
  assign stats.failed  = 64'(event_count[RESP_FAILED]);
  assign stats.paged   = 64'(event_count[RESP_PAGED]);
  assign stats.cycle   = 64'(cycle_count);

endmodule

// ==== src/mmio_resp.sv ====
// Writes and parity errors return zero data; a held response blocks the whole pipeline
`timescale 1ns/1ps

module mmio_resp (
  input  logic                 clock,
  input  logic                 rstn,
  input  logic                 rd_valid,
  input  logic [63:0]          rd_data,
  input  logic                 rd_error,
  input  logic                 rd_write,
  input  logic                 rd_addr_lo,
  input  logic                 rd_double,
  input  logic                 resp_ready,
  output logic                 advance,
  output logic                 resp_valid,
  output mmio_pkg::mmio_resp_t resp
);

  import mmio_pkg::*;

  logic [63:0] lane_data;

  // Output register is free or being emptied this cycle
  assign advance = !resp_valid || resp_ready;

  ////////////////////
  // Lane formatting
  ////////////////////

  always_comb begin
    if (rd_write) begin
      lane_data = '0;
    end else if (rd_double) begin
      lane_data = rd_data;
    end else if (rd_addr_lo) begin
      lane_data = {rd_data[31:0], rd_data[31:0]};
    end else begin
      lane_data = {rd_data[63:32], rd_data[63:32]};
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      resp_valid <= 1'b0;
    end else if (advance) begin
      resp_valid <= rd_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (advance && rd_valid) begin
      resp.data        <= lane_data;
      resp.data_parity <= odd_parity_of(lane_data);
      resp.error       <= rd_error;
      resp.was_write   <= rd_write;
    end
  end

  // Host sees one stable response until it takes it
  assert property (@(posedge clock) disable iff (!rstn)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

// ==== src/mmio_top.sv ====
// Three-stage MMIO path with in-order responses; req_ready drops whenever a response is stalled
`timescale 1ns/1ps

module mmio_top #(
  parameter int COUNT_W = 32
) (
  input  logic                 clock,
  input  logic                 rstn,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  mmio_pkg::mmio_req_t  req,
  output logic                 resp_valid,
  input  logic                 resp_ready,
  output mmio_pkg::mmio_resp_t resp,
  input  mmio_pkg::cu_resp_t   cu_resp,
  input  logic [63:0]          cu_status,
  output logic [63:0]          cu_configure,
  output logic [63:0]          afu_configure,
  output logic [1:0]           mmio_errors
);

  logic                  advance;
  logic                  op_valid;
  mmio_pkg::mmio_op_t    op;
  mmio_pkg::resp_stats_t stats;
  logic                  stat_clear;
  logic                  rd_valid;
  logic [63:0]           rd_data;
  logic                  rd_error;
  logic                  rd_write;
  logic                  rd_addr_lo;
  logic                  rd_double;

  assign req_ready = advance;

  mmio_req_check u_req_check (
    .clock    (clock),
    .rstn     (rstn),
    .advance  (advance),
    .req_valid(req_valid),
    .req      (req),
    .op_valid (op_valid),
    .op       (op)
  );

  mmio_regs u_regs (
    .clock        (clock),
    .rstn         (rstn),
    .advance      (advance),
    .op_valid     (op_valid),
    .op           (op),
    .cu_status    (cu_status),
    .stats        (stats),
    .stat_clear   (stat_clear),
    .cu_configure (cu_configure),
    .afu_configure(afu_configure),
    .mmio_errors  (mmio_errors),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data),
    .rd_error     (rd_error),
    .rd_write     (rd_write),
    .rd_addr_lo   (rd_addr_lo),
    .rd_double    (rd_double)
  );

  response_counters #(
    .COUNT_W(COUNT_W)
  ) u_counters (
    .clock     (clock),
    .rstn      (rstn),
    .cu_resp   (cu_resp),
    .stat_clear(stat_clear),
    .stats     (stats)
  );

  mmio_resp u_resp (
    .clock     (clock),
    .rstn      (rstn),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .rd_error  (rd_error),
    .rd_write  (rd_write),
    .rd_addr_lo(rd_addr_lo),
    .rd_double (rd_double),
    .resp_ready(resp_ready),
    .advance   (advance),
    .resp_valid(resp_valid),
    .resp      (resp)
  );

endmodule

// ==== testbench/tb_mmio_top.sv ====
// Runs with COUNT_W of 32; cu_status is a constant, and cycle-count reads are only checked for growth
`timescale 1ns/1ps

module tb_mmio_top;

  import mmio_pkg::*;

  localparam int CLOCK_PERIOD = 40;
  localparam int B2B_COUNT    = 24;
  // Rough cycle budget for the five tests in run order
  localparam int TEST_CYCLES  = 70 + 70 + 50 + 100 + 60;
  localparam int WATCHDOG_NS  = TEST_CYCLES * 4 * CLOCK_PERIOD;

  typedef struct packed {
    logic       check_data;
    mmio_resp_t resp;
  } expect_t;

  logic         clock = 1'b0;
  logic         rstn;
  logic         req_valid;
  logic         req_ready;
  mmio_req_t    req;
  logic         resp_valid;
  logic         resp_ready;
  mmio_resp_t   resp;
  cu_resp_t     cu_resp;
  logic [63:0]  cu_status;
  logic [63:0]  cu_configure;
  logic [63:0]  afu_configure;
  logic [1:0]   mmio_errors;

  // Reference register model
  logic [63:0]  m_cu_cfg = '0;
  logic [63:0]  m_afu_cfg = '0;
  logic [1:0]   m_errors = '0;
  int           event_counts [4] = '{0, 0, 0, 0};
  expect_t      exp_q [$];

  logic [31:0]  rng = 32'd2080;
  int           cycle_no = 0;
  int           accept_cycle;
  int           first_valid_cycle;
  int           check_count = 0;
  int           error_count = 0;

  mmio_top #(
    .COUNT_W(32)
  ) u_mmio_top (
    .clock        (clock),
    .rstn         (rstn),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req          (req),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready),
    .resp         (resp),
    .cu_resp      (cu_resp),
    .cu_status    (cu_status),
    .cu_configure (cu_configure),
    .afu_configure(afu_configure),
    .mmio_errors  (mmio_errors)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  always @(posedge clock) begin
    cycle_no <= cycle_no + 1;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Bit that makes the number of ones odd
  function automatic logic odd_bit(input logic [63:0] value);
    int ones;
    ones = 0;
    for (int i = 0; i < 64; i++) begin
      ones += value[i];
    end
    return (ones % 2) == 0;
  endfunction

  function automatic mmio_req_t make_req(input logic cfg, input logic read, input logic dw,
                                         input logic [23:0] addr, input logic [63:0] data);
    mmio_req_t r;
    r.cfg            = cfg;
    r.read           = read;
    r.doubleword     = dw;
    r.address        = addr;
    r.address_parity = odd_bit({40'b0, addr});
    r.data           = data;
    r.data_parity    = odd_bit(data);
    return r;
  endfunction

  function automatic mmio_req_t read_req(input logic [23:0] addr, input logic dw);
    return make_req(1'b0, 1'b1, dw, addr, '0);
  endfunction

  function automatic mmio_req_t write_req(input logic [23:0] addr, input logic dw,
                                          input logic [63:0] data);
    return make_req(1'b0, 1'b0, dw, addr, data);
  endfunction

  function automatic mmio_req_t desc_read_req(input logic [23:0] addr, input logic dw);
    return make_req(1'b1, 1'b1, dw, addr, '0);
  endfunction

  // Odd address picks the low 32 bits
  function automatic logic [63:0] apply_write(input logic [63:0] old_value,
                                              input logic [63:0] data,
                                              input logic dw, input logic lo);
    logic [63:0] value;
    value = old_value;
    if (dw) begin
      value = data;
    end else if (lo) begin
      value[31:0] = data[31:0];
    end else begin
      value[63:32] = data[63:32];
    end
    return value;
  endfunction

  task automatic check_value(input string name, input logic [95:0] actual,
                             input logic [95:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  ////////////////////
  // Model
  ////////////////////

  task automatic model_request(input mmio_req_t r);
    expect_t     e;
    logic [23:0] a;
    logic [23:0] word;
    logic        lo;
    logic        addr_err;
    logic        data_err;
    logic [63:0] v;
    a        = r.address;
    word     = {a[23:1], 1'b0};
    lo       = a[0];
    addr_err = odd_bit({40'b0, a}) != r.address_parity;
    data_err = !r.read && (odd_bit(r.data) != r.data_parity);
    e        = '0;
    e.check_data = 1'b1;
    v        = '0;
    if (addr_err || data_err) begin
      m_errors = m_errors | {data_err, addr_err};
      e.resp.error = 1'b1;
    end else if (!r.read) begin
      e.resp.was_write = 1'b1;
      if (!r.cfg) begin
        case (word)
          CU_CONFIGURE:  m_cu_cfg  = apply_write(m_cu_cfg, r.data, r.doubleword, lo);
          AFU_CONFIGURE: m_afu_cfg = apply_write(m_afu_cfg, r.data, r.doubleword, lo);
          ERROR_ACK:     m_errors  = m_errors & ~((r.doubleword || lo) ? r.data[1:0]
                                                                       : r.data[33:32]);
          STAT_CLEAR:    event_counts = '{0, 0, 0, 0};
          default: ;
        endcase
      end
    end else begin
      if (r.cfg) begin
        if ((a >> 1) < DESC_WORDS) begin
          v = DESCRIPTOR_TABLE[a >> 1];
        end
      end else begin
        case (word)
          CU_CONFIGURE:      v = m_cu_cfg;
          AFU_CONFIGURE:     v = m_afu_cfg;
          CU_STATUS:         v = cu_status;
          ERROR_REG:         v = {62'b0, m_errors};
          DONE_COUNT_REG:    v = 64'(event_counts[RESP_DONE]);
          FLUSHED_COUNT_REG: v = 64'(event_counts[RESP_FLUSHED]);
          FAILED_COUNT_REG:  v = 64'(event_counts[RESP_FAILED]);
          PAGED_COUNT_REG:   v = 64'(event_counts[RESP_PAGED]);
          CYCLE_COUNT_REG:   e.check_data = 1'b0;
          default:           v = '0;
        endcase
      end
      if (!r.doubleword) begin
        v = lo ? {v[31:0], v[31:0]} : {v[63:32], v[63:32]};
      end
      e.resp.data = v;
    end
    exp_q.push_back(e);
  endtask

  ////////////////////
  // Bus tasks
  ////////////////////

  // Starts and ends on a falling edge
  task automatic send_request(input mmio_req_t r);
    req       = r;
    req_valid = 1'b1;
    do begin
      @(posedge clock);
    end while (!req_ready);
    accept_cycle = cycle_no;
    @(negedge clock);
    req_valid = 1'b0;
  endtask

  task automatic collect_response(output mmio_resp_t actual);
    expect_t    e;
    mmio_resp_t held;
    logic       stalled;
    logic       taken;
    logic       seen;
    stalled = 1'b0;
    taken   = 1'b0;
    seen    = 1'b0;
    held    = '0;
    while (!taken) begin
      @(posedge clock);
      if (resp_valid) begin
        if (!seen) begin
          first_valid_cycle = cycle_no;
        end
        seen = 1'b1;
        if (stalled) begin
          check_value("resp while stalled", resp, held);
        end
        held    = resp;
        stalled = !resp_ready;
        taken   = resp_ready;
      end
    end
    actual = resp;
    if (exp_q.size() == 0) begin
      error_count++;
      $display("Response at %0t ns has no outstanding request", $time);
    end else begin
      e = exp_q.pop_front();
      check_value("resp.error", actual.error, e.resp.error);
      check_value("resp.was_write", actual.was_write, e.resp.was_write);
      if (e.check_data) begin
        check_value("resp.data", actual.data, e.resp.data);
      end
    end
    check_value("resp.data_parity", actual.data_parity, odd_bit(actual.data));
    @(negedge clock);
  endtask

  task automatic run_request(input mmio_req_t r, output mmio_resp_t actual);
    model_request(r);
    send_request(r);
    collect_response(actual);
  endtask

  task automatic check_ports();
    check_value("cu_configure", cu_configure, m_cu_cfg);
    check_value("afu_configure", afu_configure, m_afu_cfg);
    check_value("mmio_errors", mmio_errors, m_errors);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_reads();
    mmio_resp_t got;
    run_request(read_req(CU_CONFIGURE, 1'b1), got);
    check_value("response latency", 96'(first_valid_cycle - accept_cycle), 96'd3);
    run_request(read_req(AFU_CONFIGURE, 1'b1), got);
    run_request(read_req(ERROR_REG, 1'b1), got);
    run_request(read_req(CU_STATUS, 1'b1), got);
    // Two words past the end of the table
    for (int i = 0; i < DESC_WORDS + 2; i++) begin
      run_request(desc_read_req(24'(2 * i), 1'b1), got);
    end
    run_request(desc_read_req(24'h1, 1'b0), got);
    run_request(desc_read_req(24'h6, 1'b0), got);
    check_ports();
  endtask

  task automatic test_write_read();
    mmio_resp_t got;
    run_request(write_req(CU_CONFIGURE, 1'b1, {next_rand(), next_rand()}), got);
    check_ports();
    run_request(read_req(CU_CONFIGURE, 1'b1), got);
    run_request(write_req(CU_CONFIGURE | 24'h1, 1'b0, {next_rand(), next_rand()}), got);
    check_ports();
    run_request(read_req(CU_CONFIGURE | 24'h1, 1'b0), got);
    run_request(read_req(CU_CONFIGURE, 1'b0), got);
    run_request(read_req(CU_CONFIGURE, 1'b1), got);
    run_request(write_req(AFU_CONFIGURE, 1'b0, {next_rand(), next_rand()}), got);
    check_ports();
    run_request(read_req(AFU_CONFIGURE, 1'b1), got);
    run_request(write_req(AFU_CONFIGURE, 1'b1, {next_rand(), next_rand()}), got);
    run_request(read_req(AFU_CONFIGURE | 24'h1, 1'b0), got);
    // Descriptor space ignores writes
    run_request(make_req(1'b1, 1'b0, 1'b1, 24'h0, 64'hDEAD_BEEF_0000_FFFF), got);
    run_request(desc_read_req(24'h0, 1'b1), got);
    check_ports();
  endtask

  task automatic test_parity_errors();
    mmio_resp_t got;
    mmio_req_t  r;
    r = read_req(CU_CONFIGURE, 1'b1);
    r.address_parity = ~r.address_parity;
    run_request(r, got);
    check_ports();
    run_request(read_req(ERROR_REG, 1'b1), got);
    r = write_req(CU_CONFIGURE, 1'b1, 64'h0123_4567_89AB_CDEF);
    r.data_parity = ~r.data_parity;
    run_request(r, got);
    check_ports();
    run_request(read_req(ERROR_REG, 1'b1), got);
    run_request(write_req(ERROR_ACK, 1'b1, 64'h1), got);
    check_ports();
    run_request(write_req(ERROR_ACK, 1'b1, 64'h2), got);
    check_ports();
    run_request(read_req(ERROR_REG, 1'b1), got);
  endtask

  task automatic test_statistics();
    mmio_resp_t  got;
    logic [31:0] r;
    logic [63:0] first_cycle;
    repeat (40) begin
      r = next_rand();
      cu_resp.valid = r[0];
      cu_resp.code  = cu_resp_code_e'(r[2:1]);
      if (r[0]) begin
        event_counts[r[2:1]]++;
      end
      @(negedge clock);
    end
    cu_resp = '0;
    for (int i = 0; i < 4; i++) begin
      run_request(read_req(DONE_COUNT_REG + 24'(2 * i), 1'b1), got);
    end
    run_request(read_req(CYCLE_COUNT_REG, 1'b1), got);
    first_cycle = got.data;
    run_request(read_req(CYCLE_COUNT_REG, 1'b1), got);
    check_value("cycle count increase", got.data > first_cycle, 96'd1);
    run_request(write_req(STAT_CLEAR, 1'b1, 64'h1), got);
    for (int i = 0; i < 4; i++) begin
      run_request(read_req(DONE_COUNT_REG + 24'(2 * i), 1'b1), got);
    end
  endtask

  task automatic test_back_to_back();
    mmio_req_t   reqs [B2B_COUNT];
    logic [31:0] r;
    logic        collect_done;
    collect_done = 1'b0;
    for (int i = 0; i < B2B_COUNT; i++) begin
      r = next_rand();
      case (r[2:0])
        3'd0:    reqs[i] = write_req(CU_CONFIGURE, 1'b1, {next_rand(), next_rand()});
        3'd1:    reqs[i] = write_req(CU_CONFIGURE | 24'(r[3]), 1'b0, {next_rand(), r});
        3'd2:    reqs[i] = write_req(AFU_CONFIGURE | 24'(r[3]), r[4], {r, next_rand()});
        3'd3:    reqs[i] = read_req(CU_CONFIGURE, 1'b1);
        3'd4:    reqs[i] = read_req(CU_CONFIGURE | 24'(r[3]), 1'b0);
        3'd5:    reqs[i] = read_req(AFU_CONFIGURE | 24'(r[3]), r[4]);
        3'd6:    reqs[i] = desc_read_req(24'(r[5:3]), r[6]);
        default: reqs[i] = read_req(ERROR_REG, 1'b1);
      endcase
    end
    fork
      begin
        for (int i = 0; i < B2B_COUNT; i++) begin
          model_request(reqs[i]);
          send_request(reqs[i]);
        end
      end
      begin
        mmio_resp_t got;
        for (int i = 0; i < B2B_COUNT; i++) begin
          collect_response(got);
        end
        collect_done = 1'b1;
      end
      // Host stalls about a quarter of the cycles
      begin
        logic [31:0] stall_rand;
        while (!collect_done) begin
          stall_rand = next_rand();
          resp_ready = stall_rand[1:0] != 2'b00;
          @(negedge clock);
        end
        resp_ready = 1'b1;
      end
    join
    check_value("outstanding expected responses", exp_q.size(), 96'd0);
    repeat (3) begin
      @(posedge clock);
      check_value("resp_valid when idle", resp_valid, 96'd0);
    end
    @(negedge clock);
    check_ports();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rstn       = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b1;
    cu_resp    = '0;
    cu_status  = 64'hA5A5_0F0F_1234_5678;
    repeat (3) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;
    test_reset_reads();
    test_write_read();
    test_parity_errors();
    test_statistics();
    test_back_to_back();
    $display("Finished: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not complete within %0d ns", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
src/mmio_pkg.sv
src/mmio_req_check.sv
src/mmio_regs.sv
src/response_counters.sv
src/mmio_resp.sv
src/mmio_top.sv
testbench/tb_mmio_top.sv
